/* rtl/sound_pkg.sv */
// ----------------------------------------------------------
// Sound front end shared types
// Pulse inputs, codec sample and pin bundles, frame sizes
// ----------------------------------------------------------

package sound_pkg;

	// Timer channels and beeper as raw one-bit pulses
	typedef struct packed {
		logic [2:0] timer;
		logic       beeper;
	} sound_pulses_t;

	// One signed codec sample
	typedef logic signed [15:0] sample_t;

	// Unsigned PCM sample from the CPU side
	typedef logic [8:0] pcm_t;

	// Pins towards the codec
	typedef struct packed {
		logic xck;
		logic bck;
		logic lrck;
		logic adclrck;
		logic dacdat;
	} codec_pins_t;

	// Slots per frame, 16 left and 16 right
	localparam int BITS_PER_FRAME = 32;
	// clk18 cycles per frame at the default bit clock
	localparam int FRAME_CYCLES = 256;

endpackage

/* rtl/sound_mix.sv */
// ----------------------------------------------------------
// Sound mixer
// Four-tap moving average over the timer pulses, decimated
// to the codec frame rate, mixed with beeper and PCM
// ----------------------------------------------------------

`timescale 1ns/1ns

module sound_mix import sound_pkg::*; (
	input  logic          clk18,
	input  logic          reset,
	input  logic          frame_start,
	input  sound_pulses_t pulses,
	input  pcm_t          pcm,
	output sample_t       dac_word
);

	// ----------------------------------------------------------
	// Timer pulse filter
	// ----------------------------------------------------------

	// Active timer channels right now, 0..3
	logic [1:0] timer_cnt;
	// Tap history, index 0 is the newest
	logic [3:0][5:0] taps;
	// Sum of four taps, at most 4 * 48
	logic [7:0] sum;
	// Mixed word before the output register
	logic [15:0] mix;

	assign timer_cnt = {1'b0, pulses.timer[0]}
		+ {1'b0, pulses.timer[1]}
		+ {1'b0, pulses.timer[2]};

	// Taps and sum move only once per codec frame
	always_ff @(posedge clk18) begin
		if (reset) begin
			taps <= '0;
			sum  <= '0;
		end else if (frame_start) begin
			// Newest tap is 16 per active channel
			taps[0] <= {2'b00, timer_cnt, 2'b00} << 2;
			taps[1] <= taps[0];
			taps[2] <= taps[1];
			taps[3] <= taps[2];
			// Sum of the taps as they were before this shift
			sum <= 8'(taps[0]) + 8'(taps[1]) + 8'(taps[2]) + 8'(taps[3]);
		end
	end

	// ----------------------------------------------------------
	// Mixer
	// ----------------------------------------------------------

	// Average times 128, beeper at 8192, pcm times 32
	// Peak is 6144 + 8192 + 16352, still positive in 16 bits
	assign mix = {3'b000, sum[7:2], 7'b0000000}
		+ {2'b00, pulses.beeper, 13'b0}
		+ {2'b00, pcm, 5'b00000};

	// Beeper and pcm skip the filter and keep their edges
	always_ff @(posedge clk18) begin
		if (reset) begin
			dac_word <= '0;
		end else begin
			dac_word <= sample_t'(mix);
		end
	end

	// Filter sum stays within four full-scale taps
	sum_range_a: assert property (
		@(posedge clk18) disable iff (reset)
		sum <= 8'd192
	);

endmodule

/* rtl/codec_serial.sv */
// ----------------------------------------------------------
// Codec serial port
// One frame counter makes bck, lrck and frame_start
// I2S style DAC shifter and left-channel ADC capture
// ----------------------------------------------------------

`timescale 1ns/1ns

module codec_serial import sound_pkg::*; #(
	parameter int BCK_HALF = 4
) (
	input  logic        clk18,
	input  logic        reset,
	input  sample_t     dac_word,
	input  logic        adcdat,
	output codec_pins_t pins,
	output logic        frame_start,
	output sample_t     line_word,
	output logic        line_valid
);

	// ----------------------------------------------------------
	// Frame counter layout
	// ----------------------------------------------------------

	// BCK_HALF is a power of two, 2 or 4 in practice
	localparam int HB = $clog2(BCK_HALF);
	localparam int SB = $clog2(BITS_PER_FRAME);
	// Counter width, frame length is 2**CW cycles
	localparam int CW = HB + 1 + SB;
	localparam int WORD = $bits(sample_t);

	logic [CW-1:0] cnt;
	logic [SB-1:0] slot;
	logic          bck;
	logic          lrck;
	logic          bck_fall;
	logic          bck_rise;
	logic          frame_end;

	// Bit clock low half, then high half
	assign bck  = cnt[HB];
	// Left half low, right half high
	assign lrck = cnt[CW-1];
	assign slot = cnt[CW-1:HB+1];

	// Next clock edge moves bck
	assign bck_fall = &cnt[HB:0];
	assign bck_rise = (cnt[HB:0] == {1'b0, {HB{1'b1}}});

	assign frame_start = (cnt == '0);
	// One cycle before the last cycle of the frame
	assign frame_end = (cnt == {{(CW-1){1'b1}}, 1'b0});

	always_ff @(posedge clk18) begin
		if (reset) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// ----------------------------------------------------------
	// DAC side
	// ----------------------------------------------------------

	// Latched word, rotated so right slot repeats it
	logic [WORD-1:0] dac_sr;
	logic            dac_bit;

	always_ff @(posedge clk18) begin
		if (frame_start) begin
			dac_sr <= dac_word;
		end else if (bck_fall) begin
			dac_sr <= {dac_sr[WORD-2:0], dac_sr[WORD-1]};
		end
	end

	// MSB lands one bit clock after lrck moves
	always_ff @(posedge clk18) begin
		if (reset) begin
			dac_bit <= 1'b0;
		end else if (bck_fall) begin
			dac_bit <= dac_sr[WORD-1];
		end
	end

	assign pins = '{
		xck:     clk18,
		bck:     bck,
		lrck:    lrck,
		adclrck: lrck,
		dacdat:  dac_bit
	};

	// ----------------------------------------------------------
	// ADC side
	// ----------------------------------------------------------

	sample_t adc_sr;

	// Left word sits in slots 1 to 16
	always_ff @(posedge clk18) begin
		if (bck_rise && slot != '0 && slot <= SB'(WORD)) begin
			adc_sr <= {adc_sr[WORD-2:0], adcdat};
		end
	end

	always_ff @(posedge clk18) begin
		if (frame_end) begin
			line_word <= adc_sr;
		end
	end

	// High in the last cycle of every frame
	always_ff @(posedge clk18) begin
		if (reset) begin
			line_valid <= 1'b0;
		end else begin
			line_valid <= frame_end;
		end
	end

	// Word select moves only together with a falling bit clock
	lrck_edge_a: assert property (
		@(posedge clk18) disable iff (reset)
		$changed(lrck) |-> $fell(bck)
	);

	// Frame boundary strobes never overlap
	strobe_excl_a: assert property (
		@(posedge clk18) disable iff (reset)
		!(frame_start && line_valid)
	);

endmodule

/* rtl/tape_slicer.sv */
// ----------------------------------------------------------
// Tape input slicer
// Line-in level to tape bit, comparator with hysteresis
// ----------------------------------------------------------

`timescale 1ns/1ns

module tape_slicer import sound_pkg::*; #(
	parameter int HYST = 4
) (
	input  logic    clk18,
	input  logic    reset,
	input  sample_t line_word,
	input  logic    line_valid,
	output logic    tapein
);

	// Thresholds around the 128 midpoint
	localparam logic [7:0] LEVEL_HI = 8'(128 + HYST);
	localparam logic [7:0] LEVEL_LO = 8'(128 - HYST);

	// Offset binary, 0..255
	logic [7:0] level;

	assign level = {~line_word[15], line_word[14:8]};

	// Set above, clear below, hold in between
	always_ff @(posedge clk18) begin
		if (reset) begin
			tapein <= 1'b0;
		end else if (line_valid) begin
			if (level > LEVEL_HI) begin
				tapein <= 1'b1;
			end else if (level < LEVEL_LO) begin
				tapein <= 1'b0;
			end
		end
	end

	// Tape bit moves only right after a captured frame
	tape_update_a: assert property (
		@(posedge clk18) disable iff (reset)
		$changed(tapein) |-> $past(line_valid)
	);

endmodule

/* rtl/soundcodec.sv */
// ----------------------------------------------------------
// Sound codec front end
// Mixer to codec serial port, line-in to tape bit
// ----------------------------------------------------------

`timescale 1ns/1ns

module soundcodec import sound_pkg::*; #(
	parameter int HYST     = 4,
	parameter int BCK_HALF = 4
) (
	input  logic          clk18,
	input  logic          reset,
	input  sound_pulses_t pulses,
	input  pcm_t          pcm,
	input  logic          adcdat,
	output codec_pins_t   pins,
	output logic          tapein
);

	// Decimation enable from the frame counter
	logic    frame_start;
	// Mixed word towards the DAC
	sample_t dac_word;
	// Left ADC word and its strobe
	sample_t line_word;
	logic    line_valid;

	sound_mix mix0 (
		.clk18       (clk18),
		.reset       (reset),
		.frame_start (frame_start),
		.pulses      (pulses),
		.pcm         (pcm),
		.dac_word    (dac_word)
	);

	codec_serial #(
		.BCK_HALF (BCK_HALF)
	) serial0 (
		.clk18       (clk18),
		.reset       (reset),
		.dac_word    (dac_word),
		.adcdat      (adcdat),
		.pins        (pins),
		.frame_start (frame_start),
		.line_word   (line_word),
		.line_valid  (line_valid)
	);

	tape_slicer #(
		.HYST (HYST)
	) slicer0 (
		.clk18      (clk18),
		.reset      (reset),
		.line_word  (line_word),
		.line_valid (line_valid),
		.tapein     (tapein)
	);

endmodule

/* tests/codec_model.sv */
// ----------------------------------------------------------
// Behavioral stereo codec
// Deserializes DAC frames, serializes queued ADC words,
// and measures bit clock and word select timing
// ----------------------------------------------------------

`timescale 1ns/1ns

module codec_model import sound_pkg::*; #(
	// Shortest allowed gap between dacdat and a bck rise, ns
	parameter int MIN_GAP = 40
) (
	input  codec_pins_t pins,
	output logic        adcdat
);

	localparam int WORD = $bits(sample_t);

	// DAC receive state
	sample_t dac_sr;
	sample_t left_word;
	logic    prev_lrck;
	int      bit_cnt;
	sample_t rx_left[$];
	sample_t rx_right[$];
	int      rx_count;
	int      short_words;

	// Timing as seen on the pins
	time last_bck_rise;
	time last_lrck_rise;
	time last_dac_change;
	time bck_period;
	time lrck_period;
	int  hold_errors;

	// ADC transmit state
	sample_t adc_queue[$];
	sample_t adc_word;
	int      adc_slot;
	logic    adc_prev_lrck;
	logic    adc_synced;
	int      adc_sent;

	initial begin
		adcdat = 1'b0;
		dac_sr = '0;
		left_word = '0;
		prev_lrck = 1'b0;
		bit_cnt = 0;
		rx_count = 0;
		short_words = 0;
		last_bck_rise = 0;
		last_lrck_rise = 0;
		last_dac_change = 0;
		bck_period = 0;
		lrck_period = 0;
		hold_errors = 0;
		adc_word = '0;
		adc_slot = 0;
		adc_prev_lrck = 1'b0;
		adc_synced = 1'b0;
		adc_sent = 0;
	end

	// ----------------------------------------------------------
	// DAC side
	// ----------------------------------------------------------

	// One bit per rising bck, word ends on the slot where lrck moved
	always @(posedge pins.bck) begin
		if (last_bck_rise != 0) begin
			bck_period = $time - last_bck_rise;
		end
		if ($time - last_dac_change < MIN_GAP) begin
			hold_errors++;
		end
		last_bck_rise = $time;
		dac_sr = {dac_sr[WORD-2:0], pins.dacdat};
		bit_cnt++;
		if (pins.lrck != prev_lrck) begin
			if (bit_cnt < WORD) begin
				short_words++;
			end
			// lrck high now, so the left word just ended
			if (pins.lrck) begin
				left_word = dac_sr;
			end else begin
				rx_left.push_back(left_word);
				rx_right.push_back(dac_sr);
				rx_count++;
			end
			bit_cnt = 0;
		end
		prev_lrck = pins.lrck;
	end

	// Data must stay away from the sampling edge
	always @(pins.dacdat) begin
		if (last_bck_rise != 0 && $time - last_bck_rise < MIN_GAP) begin
			hold_errors++;
		end
		last_dac_change = $time;
	end

	always @(posedge pins.lrck) begin
		if (last_lrck_rise != 0) begin
			lrck_period = $time - last_lrck_rise;
		end
		last_lrck_rise = $time;
	end

	// ----------------------------------------------------------
	// ADC side
	// ----------------------------------------------------------

	// Slot 0 starts where adclrck falls, MSB goes out in slot 1
	always @(negedge pins.bck) begin
		#1;
		if (!pins.adclrck && adc_prev_lrck) begin
			adc_synced = 1'b1;
			adc_slot = 0;
			if (adc_queue.size() > 0) begin
				adc_word = adc_queue.pop_front();
				adc_sent++;
			end else begin
				// Idle line sits at the midpoint
				adc_word = '0;
			end
		end
		adc_prev_lrck = pins.adclrck;
		if (adc_synced && adc_slot >= 1 && adc_slot <= WORD) begin
			adcdat = adc_word[WORD-adc_slot];
		end else begin
			adcdat = 1'b0;
		end
		adc_slot++;
	end

	task automatic queue_adc(input sample_t word);
		adc_queue.push_back(word);
	endtask

	// Left word in the upper half
	function automatic logic [31:0] rx_frame(input int idx);
		return {rx_left[idx], rx_right[idx]};
	endfunction

endmodule

/* tests/soundcodec_tb.sv */
// ----------------------------------------------------------
// Sound codec front end testbench
// Directed tests for reset, frame format, PCM, timer filter
// and tape slicer against a behavioral codec
// ----------------------------------------------------------

`timescale 1ns/1ns

module soundcodec_tb import sound_pkg::*; ();

	localparam int HYST = 4;
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	// Frames per test: reset, format, pcm, timer, tape
	localparam int TEST_FRAMES = 2 + 3 + 13 + 56 + 16;
	localparam logic [15:0] LFSR_SEED = 16'd21530;
	// x^16 + x^14 + x^13 + x^11 + 1
	localparam logic [15:0] LFSR_TAPS = 16'hB400;

	logic          clk18;
	logic          reset;
	sound_pulses_t pulses;
	pcm_t          pcm;
	logic          adcdat;
	codec_pins_t   pins;
	logic          tapein;

	int          errors;
	int          checks;
	logic [15:0] lfsr_state;

	always #(CLK_PERIOD / 2) clk18 = ~clk18;

	soundcodec #(
		.HYST     (HYST),
		.BCK_HALF (4)
	) dut0 (
		.clk18  (clk18),
		.reset  (reset),
		.pulses (pulses),
		.pcm    (pcm),
		.adcdat (adcdat),
		.pins   (pins),
		.tapein (tapein)
	);

	codec_model model0 (
		.pins   (pins),
		.adcdat (adcdat)
	);

	// ----------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------

	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ LFSR_TAPS;
		end
		return state >> 1;
	endfunction

	// One LFSR step per bit
	task automatic take_bits(input int n, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[14:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic check_value(input string test, input int expected, input int actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("error in %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk18);
		#2;
	endtask

	// Block until the model holds target frames, two frames each at most
	task automatic wait_received(input string test, input int target);
		int guard;
		int limit;
		guard = 0;
		limit = (target - model0.rx_count + 1) * 2 * FRAME_CYCLES;
		while (model0.rx_count < target && guard < limit) begin
			next_cycle();
			guard++;
		end
		if (model0.rx_count < target) begin
			errors++;
			$display("error in %s: codec model never received frame %0d", test, target);
		end
	endtask

	// Mixed DAC word once the filter has settled
	function automatic int expected_word(input int count, input int beep, input int sample);
		return 2048 * count + 8192 * beep + 32 * sample;
	endfunction

	// Comparator with hysteresis around 128
	function automatic logic tape_rule(input int level, input logic held);
		if (level > 128 + HYST) begin
			return 1'b1;
		end
		if (level < 128 - HYST) begin
			return 1'b0;
		end
		return held;
	endfunction

	// ----------------------------------------------------------
	// Tests
	// ----------------------------------------------------------

	task automatic test_reset_state();
		logic [31:0] frame;
		reset = 1'b1;
		repeat (RESET_CYCLES) begin
			next_cycle();
			check_value("reset_state", 0, pins.bck);
			check_value("reset_state", 0, pins.lrck);
			check_value("reset_state", 0, pins.dacdat);
			check_value("reset_state", 0, tapein);
		end
		reset = 1'b0;
		next_cycle();
		check_value("reset_state", 0, pins.bck);
		check_value("reset_state", 0, pins.lrck);
		check_value("reset_state", 0, pins.dacdat);
		check_value("reset_state", 0, tapein);
		wait_received("reset_state", 1);
		frame = model0.rx_frame(0);
		check_value("reset_state", 0, frame[31:16]);
		check_value("reset_state", 0, frame[15:0]);
	endtask

	task automatic test_frame_format();
		wait_received("frame_format", model0.rx_count + 2);
		check_value("frame_format", 8 * CLK_PERIOD, int'(model0.bck_period));
		check_value("frame_format", FRAME_CYCLES * CLK_PERIOD, int'(model0.lrck_period));
		check_value("frame_format", 0, model0.hold_errors);
		check_value("frame_format", 0, model0.short_words);
		// Codec master clock is clk18 itself
		@(negedge clk18);
		#2;
		check_value("frame_format", 0, pins.xck);
		next_cycle();
		check_value("frame_format", 1, pins.xck);
	endtask

	// New value early in a frame, so the next frame carries it
	task automatic test_pcm_path();
		logic [15:0] r;
		logic [31:0] frame;
		pcm_t        value;
		int          prev;
		int          base;
		pulses = '0;
		prev = -1;
		wait_received("pcm_path", model0.rx_count + 1);
		for (int i = 0; i < 6; i++) begin
			take_bits(9, r);
			value = r[8:0];
			pcm = value;
			base = model0.rx_count;
			wait_received("pcm_path", base + 2);
			if (prev >= 0) begin
				frame = model0.rx_frame(base);
				check_value("pcm_path", 32 * prev, frame[31:16]);
				check_value("pcm_path", 32 * prev, frame[15:0]);
			end
			frame = model0.rx_frame(base + 1);
			check_value("pcm_path", 32 * value, frame[31:16]);
			check_value("pcm_path", 32 * value, frame[15:0]);
			prev = value;
		end
	endtask

	// Four frame strobes fill the taps, one more reaches the shifter
	task automatic test_timer_average();
		logic [2:0]  timer_pat [4] = '{3'b000, 3'b010, 3'b101, 3'b111};
		logic [15:0] r;
		logic [31:0] frame;
		int          base;
		int          want;
		for (int b = 0; b < 2; b++) begin
			for (int t = 0; t < 4; t++) begin
				take_bits(9, r);
				pulses.timer = timer_pat[t];
				pulses.beeper = b[0];
				pcm = r[8:0];
				base = model0.rx_count;
				wait_received("timer_average", base + 7);
				want = expected_word($countones(timer_pat[t]), b, r[8:0]);
				frame = model0.rx_frame(base + 6);
				check_value("timer_average", want, frame[31:16]);
				check_value("timer_average", want, frame[15:0]);
			end
		end
	endtask

	task automatic test_tape_slicer();
		int          levels [8] = '{100, 131, 133, 127, 125, 130, 140, 120};
		logic [15:0] r;
		logic [7:0]  level;
		logic        expect_tape;
		int          sent;
		int          guard;
		// Only midpoint words so far
		expect_tape = 1'b0;
		for (int i = 0; i < 8; i++) begin
			take_bits(8, r);
			level = levels[i][7:0];
			sent = model0.adc_sent;
			model0.queue_adc({level ^ 8'h80, r[7:0]});
			guard = 0;
			while (model0.adc_sent == sent && guard < 2 * FRAME_CYCLES) begin
				next_cycle();
				guard++;
			end
			if (model0.adc_sent == sent) begin
				errors++;
				$display("error in tape_slicer: codec model never sent ADC word %0d", i);
			end
			// Capture at frame end, tape bit one cycle after line_valid
			repeat (FRAME_CYCLES) @(posedge clk18);
			#2;
			expect_tape = tape_rule(levels[i], expect_tape);
			check_value("tape_slicer", expect_tape, tapein);
		end
	endtask

	// ----------------------------------------------------------
	// Run
	// ----------------------------------------------------------

	initial begin
		#(2 * TEST_FRAMES * FRAME_CYCLES * CLK_PERIOD);
		$display("timeout: tests still running after %0d frames", 2 * TEST_FRAMES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		clk18 = 1'b0;
		reset = 1'b1;
		pulses = '0;
		pcm = '0;
		errors = 0;
		checks = 0;
		lfsr_state = LFSR_SEED;
		test_reset_state();
		test_frame_format();
		test_pcm_path();
		test_timer_average();
		test_tape_slicer();
		$display("tests done: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* build.f */
rtl/sound_pkg.sv
rtl/sound_mix.sv
rtl/codec_serial.sv
rtl/tape_slicer.sv
rtl/soundcodec.sv
tests/codec_model.sv
tests/soundcodec_tb.sv
